// ==== procyon_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Widths, LSU opcodes and the packed structs shared by the load queue,
// the miss handling queue and the load unit top level
// Modules import it in their bodies and use scoped names on their ports
// ~~~~~~~~~~~~~~~~~~~~

package procyon_pkg;

    // Byte address width and reorder buffer tag width
    localparam int ADDR_WIDTH        = 32;
    localparam int ROB_TAG_WIDTH     = 6;

    // A cache line is 16 bytes, so the low 4 address bits select the byte
    localparam int LINE_OFFSET_WIDTH = 4;

    // Number of outstanding cache lines the miss handling queue can track
    localparam int MHQ_DEPTH         = 4;

    typedef logic [ADDR_WIDTH-1:0]        procyon_addr_t;
    typedef logic [ROB_TAG_WIDTH-1:0]     procyon_tag_t;
    typedef logic [$clog2(MHQ_DEPTH)-1:0] procyon_mhq_tag_t;

    // LSU opcodes, loads first and stores in the upper codes
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b011,
        LSU_FUNC_LHU = 3'b100,
        LSU_FUNC_SB  = 3'b101,
        LSU_FUNC_SH  = 3'b110,
        LSU_FUNC_SW  = 3'b111
    } procyon_lsu_func_t;

    // Load handed over by the issue stage for allocation
    typedef struct packed {
        procyon_lsu_func_t lsu_func;
        procyon_tag_t      tag;
        procyon_addr_t     addr;
    } lq_alloc_t;

    // Load sent back to the execute stage when it replays
    typedef struct packed {
        procyon_lsu_func_t lsu_func;
        procyon_addr_t     addr;
        procyon_tag_t      tag;
    } lq_replay_t;

    // Store leaving the store queue, used for overlap checks
    typedef struct packed {
        procyon_addr_t     addr;
        procyon_lsu_func_t lsu_func;
    } sq_retire_t;

    // Fill broadcast payload, qualified by a separate enable
    typedef struct packed {
        procyon_mhq_tag_t  tag;
    } mhq_fill_t;

endpackage

// ==== lsu_lq.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Load queue, tracks issued loads until the reorder buffer retires them
// Flags loads overlapped by a retiring store and replays loads that
// missed in the cache once the MHQ broadcasts their fill
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_lq #(
    parameter int lq_depth = 8
) (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic                          i_flush,
    output logic                          o_full,

    // Allocation from the issue stage
    input  logic                          i_alloc_en,
    input  procyon_pkg::lq_alloc_t        i_alloc,
    output logic [lq_depth-1:0]           o_alloc_lq_select,

    // Replay towards the execute stage
    input  logic                          i_replay_stall,
    output logic                          o_replay_en,
    output logic [lq_depth-1:0]           o_replay_select,
    output procyon_pkg::lq_replay_t       o_replay,

    // Miss report from the execute stage, tag and full come from the MHQ
    input  logic                          i_update_en,
    input  logic [lq_depth-1:0]           i_update_select,
    input  logic                          i_update_retry,
    input  procyon_pkg::procyon_mhq_tag_t i_update_mhq_tag,
    input  logic                          i_update_mhq_full,

    // Fill broadcast from the MHQ
    input  logic                          i_mhq_fill_en,
    input  procyon_pkg::mhq_fill_t        i_mhq_fill,

    // Retiring store from the store queue
    input  logic                          i_sq_retire_en,
    input  procyon_pkg::sq_retire_t       i_sq_retire,

    // Load retirement from the reorder buffer
    input  logic                          i_rob_retire_en,
    input  procyon_pkg::procyon_tag_t     i_rob_retire_tag,
    output logic                          o_rob_retire_ack,
    output logic                          o_rob_retire_misspeculated
);

    import procyon_pkg::*;

    localparam int idx_width = (lq_depth > 1) ? $clog2(lq_depth) : 1;

    typedef logic [lq_depth-1:0]  lq_vec_t;
    typedef logic [idx_width-1:0] lq_idx_t;

    // Per-slot payload, written when the load is allocated or misses
    lq_alloc_t        slot_info [lq_depth];
    procyon_mhq_tag_t slot_mhq_tag [lq_depth];
    lq_vec_t          slot_retry;

    // Per-slot control bits, one bit per slot
    lq_vec_t          slot_valid;
    lq_vec_t          slot_needs_replay;
    lq_vec_t          slot_replay_rdy;
    lq_vec_t          slot_misspec;

    lq_vec_t          needs_replay_next;
    lq_vec_t          replay_rdy_next;
    lq_vec_t          misspec_next;

    lq_vec_t          empty_vec;
    lq_vec_t          alloc_select;
    lq_vec_t          update_select;
    lq_vec_t          retire_select;
    lq_vec_t          overlap_select;
    lq_vec_t          replay_ready;
    lq_vec_t          replay_select;
    lq_idx_t          replay_slot;
    logic             update_fill_hit;
    procyon_addr_t    store_end;

    // Full is a plain level straight from the valid bits
    assign empty_vec     = ~slot_valid;
    assign o_full        = &slot_valid;

    // Lowest empty slot wins, nothing is picked when the queue is full
    assign alloc_select  = {lq_depth{i_alloc_en}} & empty_vec & ~(empty_vec - lq_vec_t'(1));

    // Lowest ready slot replays unless the execute stage stalls us
    assign replay_ready  = slot_valid & slot_replay_rdy;
    assign replay_select = {lq_depth{~i_replay_stall}} & replay_ready
                           & ~(replay_ready - lq_vec_t'(1));

    assign update_select = {lq_depth{i_update_en}} & i_update_select;

    // A fill in the same cycle as the miss report may already be the line the
    // load is about to wait for, or any fill if the MHQ turned it away
    assign update_fill_hit = i_mhq_fill_en
                             & (i_update_mhq_full | (i_mhq_fill.tag == i_update_mhq_tag));

    // Store byte range ends 1, 2 or 4 bytes past its address
    always_comb begin
        case (i_sq_retire.lsu_func)
            LSU_FUNC_SB: store_end = i_sq_retire.addr + procyon_addr_t'(1);
            LSU_FUNC_SH: store_end = i_sq_retire.addr + procyon_addr_t'(2);
            default:     store_end = i_sq_retire.addr + procyon_addr_t'(4);
        endcase
    end

    // Tag match for retirement and address match for store overlap
    always_comb begin
        for (int i = 0; i < lq_depth; i++) begin
            retire_select[i]  = i_rob_retire_en & slot_valid[i]
                                & (slot_info[i].tag == i_rob_retire_tag);
            overlap_select[i] = i_sq_retire_en & slot_valid[i]
                                & (slot_info[i].addr >= i_sq_retire.addr)
                                & (slot_info[i].addr < store_end);
        end
    end

    // Turn the one-hot replay select into a slot number
    always_comb begin
        replay_slot = '0;
        for (int i = 0; i < lq_depth; i++) begin
            if (replay_select[i]) begin
                replay_slot = lq_idx_t'(i);
            end
        end
    end

    // Next state of the replay and mis-speculation marks
    always_comb begin
        logic fill_hit;

        for (int i = 0; i < lq_depth; i++) begin
            // A waiting load wakes on its own line, or on any fill when it is a retry
            fill_hit = i_mhq_fill_en & slot_needs_replay[i]
                       & (slot_retry[i] | (i_mhq_fill.tag == slot_mhq_tag[i]));

            if (alloc_select[i] || replay_select[i]) begin
                // Fresh or re-executing load starts with clean marks
                needs_replay_next[i] = 1'b0;
                replay_rdy_next[i]   = 1'b0;
                misspec_next[i]      = 1'b0;
            end else if (update_select[i]) begin
                needs_replay_next[i] = i_update_retry;
                replay_rdy_next[i]   = i_update_retry & update_fill_hit;
                misspec_next[i]      = slot_misspec[i];
            end else begin
                needs_replay_next[i] = slot_needs_replay[i];
                replay_rdy_next[i]   = slot_replay_rdy[i] | fill_hit;
                // Loads still waiting for a replay will read the store's data anyway
                misspec_next[i]      = slot_misspec[i]
                                       | (overlap_select[i] & ~slot_needs_replay[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            slot_valid        <= '0;
            slot_needs_replay <= '0;
            slot_replay_rdy   <= '0;
            slot_misspec      <= '0;
        end else begin
            // Flush drops every entry at once
            slot_valid        <= i_flush ? '0 : ((slot_valid & ~retire_select) | alloc_select);
            slot_needs_replay <= needs_replay_next;
            slot_replay_rdy   <= replay_rdy_next;
            slot_misspec      <= misspec_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < lq_depth; i++) begin
            if (alloc_select[i]) begin
                slot_info[i] <= i_alloc;
            end
            if (update_select[i]) begin
                slot_retry[i]   <= i_update_mhq_full;
                slot_mhq_tag[i] <= i_update_mhq_tag;
            end
        end
    end

    // Registered pulses and select vectors
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_replay_en                <= 1'b0;
            o_rob_retire_ack           <= 1'b0;
            o_rob_retire_misspeculated <= 1'b0;
            o_alloc_lq_select          <= '0;
        end else begin
            o_replay_en                <= ~i_flush & (|replay_select);
            o_rob_retire_ack           <= i_rob_retire_en;
            // No match (e.g. after a flush) reports clean
            o_rob_retire_misspeculated <= |(retire_select & slot_misspec);
            o_alloc_lq_select          <= alloc_select;
        end
    end

    // Replayed load payload
    always_ff @(posedge clk) begin
        o_replay_select   <= replay_select;
        o_replay.lsu_func <= slot_info[replay_slot].lsu_func;
        o_replay.addr     <= slot_info[replay_slot].addr;
        o_replay.tag      <= slot_info[replay_slot].tag;
    end

endmodule

// ==== lsu_mhq.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Miss handling queue, merges cache misses by line and hands out MHQ tags
// Each line broadcasts a fill after a fixed memory latency
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_mhq #(
    parameter int fill_latency = 6
) (
    input  logic                          clk,
    input  logic                          n_rst,

    // Miss report from the execute stage
    input  logic                          i_miss_en,
    input  procyon_pkg::procyon_addr_t    i_miss_addr,
    output procyon_pkg::procyon_mhq_tag_t o_miss_tag,
    output logic                          o_full,

    // Fill broadcast
    output logic                          o_fill_en,
    output procyon_pkg::mhq_fill_t        o_fill
);

    import procyon_pkg::*;

    localparam int cnt_width  = (fill_latency > 1) ? $clog2(fill_latency) : 1;
    localparam int line_width = ADDR_WIDTH - LINE_OFFSET_WIDTH;

    typedef logic [MHQ_DEPTH-1:0]  mhq_vec_t;
    typedef logic [line_width-1:0] mhq_line_t;
    typedef logic [cnt_width-1:0]  mhq_cnt_t;

    // Line address and remaining latency of each entry
    mhq_line_t        entry_line [MHQ_DEPTH];
    mhq_cnt_t         entry_count [MHQ_DEPTH];
    mhq_vec_t         entry_valid;

    mhq_line_t        miss_line;
    mhq_vec_t         match_vec;
    mhq_vec_t         free_vec;
    mhq_vec_t         expired_vec;
    logic             miss_merge;
    logic             miss_alloc;
    logic             fill_found;
    procyon_mhq_tag_t match_tag;
    procyon_mhq_tag_t free_tag;
    procyon_mhq_tag_t fill_tag;

    // Number of the lowest set bit, zero when none is set
    function automatic procyon_mhq_tag_t lowest_tag(mhq_vec_t vec);
        procyon_mhq_tag_t tag;

        tag = '0;
        for (int i = MHQ_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                tag = procyon_mhq_tag_t'(i);
            end
        end
        return tag;
    endfunction

    assign miss_line = i_miss_addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH];

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            match_vec[i]   = entry_valid[i] & (entry_line[i] == miss_line);
            // Countdown at zero means memory has returned the line
            expired_vec[i] = entry_valid[i] & (entry_count[i] == '0);
        end
    end

    assign free_vec   = ~entry_valid;
    assign miss_merge = |match_vec;
    assign fill_found = |expired_vec;

    // Full only matters when the line cannot join an existing entry
    assign o_full     = ~miss_merge & ~(|free_vec);
    assign miss_alloc = i_miss_en & ~miss_merge & (|free_vec);

    assign match_tag  = lowest_tag(match_vec);
    assign free_tag   = lowest_tag(free_vec);
    assign fill_tag   = lowest_tag(expired_vec);
    assign o_miss_tag = miss_merge ? match_tag : free_tag;

    // An entry is allocated from free ones and freed from valid ones,
    // so both never hit the same entry in one cycle
    always_ff @(posedge clk) begin
        if (~n_rst) begin
            entry_valid <= '0;
            o_fill_en   <= 1'b0;
        end else begin
            o_fill_en <= fill_found;
            for (int i = 0; i < MHQ_DEPTH; i++) begin
                if (miss_alloc && (free_tag == procyon_mhq_tag_t'(i))) begin
                    entry_valid[i] <= 1'b1;
                end else if (fill_found && (fill_tag == procyon_mhq_tag_t'(i))) begin
                    entry_valid[i] <= 1'b0;
                end
            end
        end
    end

    // Countdown starts one short so the fill lands fill_latency cycles on
    always_ff @(posedge clk) begin
        o_fill.tag <= fill_tag;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (miss_alloc && (free_tag == procyon_mhq_tag_t'(i))) begin
                entry_line[i]  <= miss_line;
                entry_count[i] <= mhq_cnt_t'(fill_latency - 1);
            end else if (entry_count[i] != '0) begin
                entry_count[i] <= entry_count[i] - mhq_cnt_t'(1);
            end
        end
    end

endmodule

// ==== lsu_load_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Load side of the LSU, joins the load queue and the miss handling queue
// Miss reports go to the MHQ, its tag and full flag update the load queue
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_load_unit #(
    parameter int lq_depth     = 8,
    parameter int fill_latency = 6
) (
    input  logic                          clk,
    input  logic                          n_rst,

    input  logic                          i_flush,
    output logic                          o_full,

    // Issue stage allocation
    input  logic                          i_alloc_en,
    input  procyon_pkg::lq_alloc_t        i_alloc,
    output logic [lq_depth-1:0]           o_alloc_lq_select,

    // Replay towards the execute stage
    input  logic                          i_replay_stall,
    output logic                          o_replay_en,
    output logic [lq_depth-1:0]           o_replay_select,
    output procyon_pkg::lq_replay_t       o_replay,

    // Cache miss report from the execute stage
    input  logic                          i_miss_en,
    input  logic [lq_depth-1:0]           i_miss_select,
    input  procyon_pkg::procyon_addr_t    i_miss_addr,

    // Fill broadcast, also seen by the cache
    output logic                          o_fill_en,
    output procyon_pkg::mhq_fill_t        o_fill,

    // Store queue retirement
    input  logic                          i_sq_retire_en,
    input  procyon_pkg::sq_retire_t       i_sq_retire,

    // Reorder buffer retirement
    input  logic                          i_rob_retire_en,
    input  procyon_pkg::procyon_tag_t     i_rob_retire_tag,
    output logic                          o_rob_retire_ack,
    output logic                          o_rob_retire_misspeculated
);

    import procyon_pkg::*;

    // Same-cycle answer from the MHQ to the miss report
    procyon_mhq_tag_t miss_tag;
    logic             mhq_full;

    lsu_mhq #(
        .fill_latency(fill_latency)
    ) mhq_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_miss_en   (i_miss_en),
        .i_miss_addr (i_miss_addr),
        .o_miss_tag  (miss_tag),
        .o_full      (mhq_full),
        .o_fill_en   (o_fill_en),
        .o_fill      (o_fill)
    );

    // Every reported miss leaves the load waiting for a replay
    lsu_lq #(
        .lq_depth(lq_depth)
    ) lq_inst (
        .clk                        (clk),
        .n_rst                      (n_rst),
        .i_flush                    (i_flush),
        .o_full                     (o_full),
        .i_alloc_en                 (i_alloc_en),
        .i_alloc                    (i_alloc),
        .o_alloc_lq_select          (o_alloc_lq_select),
        .i_replay_stall             (i_replay_stall),
        .o_replay_en                (o_replay_en),
        .o_replay_select            (o_replay_select),
        .o_replay                   (o_replay),
        .i_update_en                (i_miss_en),
        .i_update_select            (i_miss_select),
        .i_update_retry             (1'b1),
        .i_update_mhq_tag           (miss_tag),
        .i_update_mhq_full          (mhq_full),
        .i_mhq_fill_en              (o_fill_en),
        .i_mhq_fill                 (o_fill),
        .i_sq_retire_en             (i_sq_retire_en),
        .i_sq_retire                (i_sq_retire),
        .i_rob_retire_en            (i_rob_retire_en),
        .i_rob_retire_tag           (i_rob_retire_tag),
        .o_rob_retire_ack           (o_rob_retire_ack),
        .o_rob_retire_misspeculated (o_rob_retire_misspeculated)
    );

endmodule

// ==== tb_clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// Free-running 8 ns clock, reset held low for the first 3 rising edges
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns  = 8,
    parameter int rst_cycles = 3
) (
    output logic clk,
    output logic n_rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Release reset on a rising edge so the DUT leaves reset cleanly
    initial begin
        n_rst = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        n_rst <= 1'b1;
    end

endmodule

// ==== lsu_load_unit_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the load unit top level
// Bound into every lsu_load_unit instance by the bind below
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_load_unit_props #(
    parameter int lq_depth = 8
) (
    input logic                clk,
    input logic                n_rst,
    input logic                i_alloc_en,
    input logic                i_rob_retire_en,
    input logic                o_full,
    input logic [lq_depth-1:0] o_alloc_lq_select,
    input logic                o_replay_en,
    input logic [lq_depth-1:0] o_replay_select,
    input logic                o_fill_en,
    input logic                o_rob_retire_ack
);

    // Every retire request gets its ack on the next edge
    a_retire_ack : assert property (@(posedge clk) disable iff (!n_rst)
        i_rob_retire_en |=> o_rob_retire_ack)
        else $error("retire enable without ack one cycle later");

    // Only one slot replays at a time
    a_replay_onehot : assert property (@(posedge clk) disable iff (!n_rst)
        o_replay_en |-> $onehot(o_replay_select))
        else $error("replay select is not one-hot");

    // Pulses stay quiet while reset is held
    a_reset_quiet : assert property (@(posedge clk)
        !n_rst |=> (!o_replay_en && !o_fill_en))
        else $error("replay or fill pulse during reset");

    // A full queue must not hand out a slot
    a_full_no_alloc : assert property (@(posedge clk) disable iff (!n_rst)
        (o_full && i_alloc_en) |=> (o_alloc_lq_select == '0))
        else $error("slot selected while the load queue was full");

endmodule

bind lsu_load_unit lsu_load_unit_props #(
    .lq_depth(lq_depth)
) props_inst (
    .clk               (clk),
    .n_rst             (n_rst),
    .i_alloc_en        (i_alloc_en),
    .i_rob_retire_en   (i_rob_retire_en),
    .o_full            (o_full),
    .o_alloc_lq_select (o_alloc_lq_select),
    .o_replay_en       (o_replay_en),
    .o_replay_select   (o_replay_select),
    .o_fill_en         (o_fill_en),
    .o_rob_retire_ack  (o_rob_retire_ack)
);

// ==== tb_lsu_load_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the load unit
// Inputs change on rising edges, outputs are checked on falling edges
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_lsu_load_unit;

    import procyon_pkg::*;

    localparam int LQ_DEPTH       = 8;
    localparam int FILL_LATENCY   = 6;
    localparam int TIMEOUT_CYCLES = 600;

    logic                clk;
    logic                n_rst;
    logic                i_flush;
    logic                i_alloc_en;
    lq_alloc_t           i_alloc;
    logic                i_replay_stall;
    logic                i_miss_en;
    logic [LQ_DEPTH-1:0] i_miss_select;
    procyon_addr_t       i_miss_addr;
    logic                i_sq_retire_en;
    sq_retire_t          i_sq_retire;
    logic                i_rob_retire_en;
    procyon_tag_t        i_rob_retire_tag;
    logic                o_full;
    logic [LQ_DEPTH-1:0] o_alloc_lq_select;
    logic                o_replay_en;
    logic [LQ_DEPTH-1:0] o_replay_select;
    lq_replay_t          o_replay;
    logic                o_fill_en;
    mhq_fill_t           o_fill;
    logic                o_rob_retire_ack;
    logic                o_rob_retire_misspeculated;

    logic [31:0]         lfsr_state = 32'd93118;
    int                  cycle_count = 0;
    logic                any_error = 1'b0;

    tb_clk_gen clk_gen_inst (.clk(clk), .n_rst(n_rst));

    lsu_load_unit #(
        .lq_depth(LQ_DEPTH),
        .fill_latency(FILL_LATENCY)
    ) UUT (.*);

    // Hard stop in case the DUT never answers
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("error: simulation ran past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1, one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        logic        fb;

        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic report_error(string name, string exp_s, string act_s);
        any_error = 1'b1;
        $display("error %s: expected %s, actual %s", name, exp_s, act_s);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) report_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_select(string name, logic [LQ_DEPTH-1:0] exp, logic [LQ_DEPTH-1:0] act);
        if (act !== exp) report_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_replay(string name, lq_replay_t exp, lq_replay_t act);
        if (act !== exp) report_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_mhq_tag(string name, procyon_mhq_tag_t exp, procyon_mhq_tag_t act);
        if (act !== exp) report_error(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    // Allocate one load and check the slot it lands in
    task automatic alloc_load(string name, procyon_lsu_func_t func, procyon_tag_t tag,
                              procyon_addr_t addr, logic [LQ_DEPTH-1:0] exp_select);
        @(posedge clk);
        i_alloc_en <= 1'b1;
        i_alloc    <= '{lsu_func: func, tag: tag, addr: addr};
        @(posedge clk);
        i_alloc_en <= 1'b0;
        @(negedge clk);
        check_select(name, exp_select, o_alloc_lq_select);
    endtask

    task automatic retire_load(string name, procyon_tag_t tag, logic exp_misspec);
        @(posedge clk);
        i_rob_retire_en  <= 1'b1;
        i_rob_retire_tag <= tag;
        @(posedge clk);
        i_rob_retire_en  <= 1'b0;
        @(negedge clk);
        check_bit({name, " ack"}, 1'b1, o_rob_retire_ack);
        check_bit({name, " misspeculated"}, exp_misspec, o_rob_retire_misspeculated);
    endtask

    task automatic retire_store(procyon_lsu_func_t func, procyon_addr_t addr);
        @(posedge clk);
        i_sq_retire_en <= 1'b1;
        i_sq_retire    <= '{addr: addr, lsu_func: func};
        @(posedge clk);
        i_sq_retire_en <= 1'b0;
    endtask

    // Holds the miss on the bus until clear_miss, so misses can go back to back
    task automatic report_miss(logic [LQ_DEPTH-1:0] select, procyon_addr_t addr);
        @(posedge clk);
        i_miss_en     <= 1'b1;
        i_miss_select <= select;
        i_miss_addr   <= addr;
    endtask

    task automatic clear_miss();
        @(posedge clk);
        i_miss_en <= 1'b0;
    endtask

    // One-cycle flush pulse, returns on the edge that takes it
    task automatic flush_queue();
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
    endtask

    // Waits on falling edges until the fill pulse shows up
    task automatic wait_fill();
        do @(negedge clk); while (!o_fill_en);
    endtask

    task automatic wait_replay();
        do @(negedge clk); while (!o_replay_en);
    endtask

    task automatic test_alloc_full();
        for (int i = 0; i < LQ_DEPTH; i++) begin
            alloc_load("alloc_full", LSU_FUNC_LW, procyon_tag_t'(i), take_bits(32),
                       LQ_DEPTH'(1) << i);
        end
        check_bit("alloc_full o_full", 1'b1, o_full);
        alloc_load("alloc_full ninth", LSU_FUNC_LW, procyon_tag_t'(8), take_bits(32), '0);
    endtask

    task automatic test_retire_reuse();
        retire_load("retire_reuse", procyon_tag_t'(3), 1'b0);
        alloc_load("retire_reuse realloc", LSU_FUNC_LB, procyon_tag_t'(8), take_bits(32),
                   8'b0000_1000);
    endtask

    task automatic test_store_overlap();
        procyon_addr_t addrs [8];
        logic          exp [8];

        // SW at 0x1000, SH at 0x2000, SB at 0x3000, slot 7 waits for replay
        addrs = '{32'h1000, 32'h1003, 32'h1004, 32'h2001, 32'h2002, 32'h3000, 32'h3001, 32'h1001};
        exp   = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
        flush_queue();
        for (int i = 0; i < LQ_DEPTH; i++) begin
            alloc_load("store_overlap alloc", LSU_FUNC_LBU, procyon_tag_t'(10 + i), addrs[i],
                       LQ_DEPTH'(1) << i);
        end
        report_miss(8'b1000_0000, addrs[7]);
        clear_miss();
        retire_store(LSU_FUNC_SW, 32'h1000);
        retire_store(LSU_FUNC_SH, 32'h2000);
        retire_store(LSU_FUNC_SB, 32'h3000);
        for (int i = 0; i < LQ_DEPTH; i++) begin
            retire_load($sformatf("store_overlap slot %0d", i), procyon_tag_t'(10 + i), exp[i]);
        end
    endtask

    task automatic test_miss_replay();
        logic [27:0]   line;
        procyon_addr_t a1;
        procyon_addr_t a2;

        line = 28'(take_bits(28));
        a1 = {line, 4'h4};
        a2 = {line, 4'hc};
        flush_queue();
        alloc_load("miss_replay alloc", LSU_FUNC_LW, procyon_tag_t'(20), a1, 8'b0000_0001);
        alloc_load("miss_replay alloc", LSU_FUNC_LHU, procyon_tag_t'(21), a2, 8'b0000_0010);
        report_miss(8'b0000_0001, a1);
        report_miss(8'b0000_0010, a2);
        clear_miss();
        i_replay_stall <= 1'b1;
        // The first miss was taken on the edge before clear_miss returned
        // Its fill lands on the FILL_LATENCY-th falling edge from here
        for (int i = 1; i < FILL_LATENCY; i++) begin
            @(negedge clk);
            check_bit("miss_replay fill early", 1'b0, o_fill_en);
        end
        @(negedge clk);
        check_bit("miss_replay fill latency", 1'b1, o_fill_en);
        check_mhq_tag("miss_replay fill tag", '0, o_fill.tag);
        repeat (4) begin
            @(negedge clk);
            check_bit("miss_replay replay while stalled", 1'b0, o_replay_en);
            check_bit("miss_replay second fill", 1'b0, o_fill_en);
        end
        @(posedge clk);
        i_replay_stall <= 1'b0;
        wait_replay();
        check_select("miss_replay first select", 8'b0000_0001, o_replay_select);
        check_replay("miss_replay first", '{lsu_func: LSU_FUNC_LW, addr: a1, tag: 6'd20}, o_replay);
        wait_replay();
        check_select("miss_replay second select", 8'b0000_0010, o_replay_select);
        check_replay("miss_replay second", '{lsu_func: LSU_FUNC_LHU, addr: a2, tag: 6'd21},
                     o_replay);
    endtask

    task automatic test_mhq_retry();
        flush_queue();
        for (int i = 0; i < 5; i++) begin
            alloc_load("mhq_retry alloc", LSU_FUNC_LH, procyon_tag_t'(30 + i),
                       32'h5000 + 32'(16 * i), LQ_DEPTH'(1) << i);
        end
        // Slots 1 to 4 fill the MHQ, slot 0 then finds it full
        for (int i = 1; i < 5; i++) begin
            report_miss(LQ_DEPTH'(1) << i, 32'h5000 + 32'(16 * i));
        end
        report_miss(8'b0000_0001, 32'h5000);
        clear_miss();
        wait_fill();
        check_mhq_tag("mhq_retry first fill tag", '0, o_fill.tag);
        wait_replay();
        check_select("mhq_retry retry select", 8'b0000_0001, o_replay_select);
        check_replay("mhq_retry retry", '{lsu_func: LSU_FUNC_LH, addr: 32'h5000, tag: 6'd30},
                     o_replay);
        for (int i = 1; i < 5; i++) begin
            wait_replay();
            check_select("mhq_retry drain select", LQ_DEPTH'(1) << i, o_replay_select);
        end
    endtask

    task automatic test_flush();
        alloc_load("flush alloc", LSU_FUNC_LB, procyon_tag_t'(35), 32'h6000, 8'b0010_0000);
        alloc_load("flush alloc", LSU_FUNC_LB, procyon_tag_t'(36), 32'h6010, 8'b0100_0000);
        alloc_load("flush alloc", LSU_FUNC_LB, procyon_tag_t'(37), 32'h6020, 8'b1000_0000);
        retire_store(LSU_FUNC_SB, 32'h6000);
        // Slot 6 misses and turns ready on the edge where the flush is driven
        report_miss(8'b0100_0000, 32'h6010);
        clear_miss();
        wait_fill();
        check_bit("flush full before flush", 1'b1, o_full);
        flush_queue();
        @(negedge clk);
        check_bit("flush full after flush", 1'b0, o_full);
        check_bit("flush replay in flush cycle", 1'b0, o_replay_en);
        repeat (3) begin
            @(negedge clk);
            check_bit("flush replay", 1'b0, o_replay_en);
        end
        retire_load("flush old misspeculated tag", procyon_tag_t'(35), 1'b0);
    endtask

    initial begin
        i_flush          = 1'b0;
        i_alloc_en       = 1'b0;
        i_alloc          = '0;
        i_replay_stall   = 1'b0;
        i_miss_en        = 1'b0;
        i_miss_select    = '0;
        i_miss_addr      = '0;
        i_sq_retire_en   = 1'b0;
        i_sq_retire      = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;

        wait (n_rst == 1'b1);
        test_alloc_full();
        test_retire_reuse();
        test_store_overlap();
        test_miss_replay();
        test_mhq_retry();
        test_flush();

        if (!any_error) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
procyon_pkg.sv
lsu_lq.sv
lsu_mhq.sv
lsu_load_unit.sv
tb_clk_gen.sv
lsu_load_unit_props.sv
tb_lsu_load_unit.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_lsu_load_unit -o sim_lsu_load_unit

./obj_dir/sim_lsu_load_unit | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
grep -q '\*\*\* PASSED \*\*\*' sim.log
